/* logic/video_data_pkg.sv */
package video_data_pkg;

	// attribute byte layout
	localparam int ATTR_INK_LSB    = 0;  // ink colour, 3 bits
	localparam int ATTR_PAPER_LSB  = 3;  // paper colour, 3 bits
	localparam int ATTR_BRIGHT_BIT = 6;  // goes to colour bit 3
	localparam int ATTR_COLOUR_W   = 3;

	// clocks each pixel is held for
	localparam int PIX_CLKS_ATTR = 2;  // 32 pixels per word
	localparam int PIX_CLKS_16C  = 4;  // 16 pixels per word

	// one bitmap byte with its attribute
	// bitmap sits in the low byte
	typedef struct packed {
		logic [7:0] attr;
		logic [7:0] bitmap;
	} attr_pair_t;

	// the 64-bit picture word, read one of two ways
	typedef union packed {
		attr_pair_t [3:0]  attr_view;  // pair 0 in bits 15:0
		logic [15:0][3:0]  nib_view;   // nibble 0 in bits 3:0
	} pic_word_t;

	typedef struct packed {
		logic       valid;   // pixel belongs to a fetched word
		logic [3:0] colour;  // 4-bit colour index
	} pixel_out_t;

endpackage

/* logic/video_fetch.sv */
`timescale 1ns/1ns

module video_fetch (
	input  logic                              clk,
	input  logic                              rst_n,
	input  video_timing_pkg::timing_strobes_t strobes,
	input  logic [15:0]                       video_data,    // word from dram arbiter
	input  logic                              video_strobe,  // one pulse per word
	output logic                              video_go,      // asks arbiter for data
	output logic                              fetch_sync,    // one clock after c3
	output video_data_pkg::pic_word_t         pic_word,      // word for renderer
	output logic                              load,
	output logic                              load_valid
);

	localparam int CTR_W = $clog2(video_timing_pkg::FETCH_CLKS / 4);  // counts slots
	localparam int PTR_W = $clog2(video_timing_pkg::WORDS_PER_FETCH);

	logic [CTR_W-1:0] fetch_ctr;      // slot within fetch cycle
	logic [PTR_W-1:0] fetch_ptr;      // next buffer entry
	logic             fetch_ptr_clr;  // one step ahead of fetch_sync
	logic             go_sampled;     // video_go at the sync that opened the cycle

	logic [15:0] fetch_data [video_timing_pkg::WORDS_PER_FETCH];  // words in arrival order

	logic [$bits(video_data_pkg::pic_word_t)-1:0] swapped;

	// request window
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			video_go <= 1'b0;
		else if (strobes.fetch_start && strobes.vpix)
			video_go <= 1'b1;
		else if (strobes.fetch_end)
			video_go <= 1'b0;
	end

	// fetch cycle counter, restarts at window start
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			fetch_ctr <= '0;
		else if (strobes.c3)
		begin
			if (strobes.fetch_start)
				fetch_ctr <= '0;
			else
				fetch_ctr <= fetch_ctr + 1'b1;
		end
	end

	// sync and pointer clear pulses
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			fetch_sync    <= 1'b0;
			fetch_ptr_clr <= 1'b0;
		end
		else
		begin
			fetch_sync    <= strobes.c3 && (fetch_ctr == CTR_W'(1));
			fetch_ptr_clr <= strobes.c3 && (fetch_ctr == CTR_W'(0));
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			fetch_ptr <= '0;
		else if (fetch_ptr_clr)
			fetch_ptr <= '0;
		else if (video_strobe)
			fetch_ptr <= fetch_ptr + 1'b1;  // no overflow guard, arbiter sends 4
	end

	always_ff @(posedge clk)
	begin
		if (video_strobe)
			fetch_data[fetch_ptr] <= video_data;
	end

	// high byte of each word goes to the lower byte lane
	always_comb
	begin
		for (int i = 0; i < video_timing_pkg::WORDS_PER_FETCH; i++)
		begin
			swapped[16*i +: 8]     = fetch_data[i][15:8];
			swapped[16*i + 8 +: 8] = fetch_data[i][7:0];
		end
	end

	always_ff @(posedge clk)
	begin
		if (fetch_sync)
			pic_word <= video_data_pkg::pic_word_t'(swapped);
	end

	// hand-off flags
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			load       <= 1'b0;
			load_valid <= 1'b0;
			go_sampled <= 1'b0;
		end
		else
		begin
			load <= fetch_sync;  // same edge as pic_word, one clock later
			if (fetch_sync)
			begin
				load_valid <= go_sampled;  // data of this cycle was requested
				go_sampled <= video_go;
			end
		end
	end

endmodule

/* logic/video_render.sv */
`timescale 1ns/1ns

module video_render (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       mode_16c,  // 1 = sixteen nibbles per word
	input  video_data_pkg::pic_word_t  pic_word,
	input  logic                       load,
	input  logic                       load_valid,
	output video_data_pkg::pixel_out_t pix
);

	// 32 pixels in attribute mode sets the index width
	localparam int IDX_W  = $clog2(video_timing_pkg::FETCH_CLKS /
	                               video_data_pkg::PIX_CLKS_ATTR);
	localparam int HOLD_W = $clog2(video_data_pkg::PIX_CLKS_16C);

	video_data_pkg::pic_word_t word_q;  // word being shifted out
	logic                      mode_q;
	logic                      valid_q;
	logic [IDX_W-1:0]          pix_idx;  // pixel k within word
	logic [HOLD_W-1:0]         hold;     // clocks spent on current pixel
	logic [HOLD_W-1:0]         hold_last;

	video_data_pkg::attr_pair_t pair;  // pair k/8
	logic                       ink_sel;
	logic [3:0]                 attr_colour;
	logic [3:0]                 nib_colour;

	assign hold_last = mode_q ? HOLD_W'(video_data_pkg::PIX_CLKS_16C - 1)
	                          : HOLD_W'(video_data_pkg::PIX_CLKS_ATTR - 1);

	always_ff @(posedge clk)
	begin
		if (load)
			word_q <= pic_word;
	end

	// pixel stepping
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			mode_q  <= 1'b0;
			valid_q <= 1'b0;
			pix_idx <= '0;
			hold    <= '0;
		end
		else if (load)
		begin
			mode_q  <= mode_16c;  // mode fixed for whole word
			valid_q <= load_valid;
			pix_idx <= '0;
			hold    <= '0;
		end
		else if (hold == hold_last)
		begin
			hold    <= '0;
			pix_idx <= pix_idx + 1'b1;
		end
		else
			hold <= hold + 1'b1;
	end

	// attribute decode, msb of bitmap first
	always_comb
	begin
		pair        = word_q.attr_view[pix_idx[4:3]];
		ink_sel     = pair.bitmap[3'd7 - pix_idx[2:0]];
		attr_colour = {pair.attr[video_data_pkg::ATTR_BRIGHT_BIT],
		               ink_sel ? pair.attr[video_data_pkg::ATTR_INK_LSB +:
		                                   video_data_pkg::ATTR_COLOUR_W]
		                       : pair.attr[video_data_pkg::ATTR_PAPER_LSB +:
		                                   video_data_pkg::ATTR_COLOUR_W]};
		nib_colour  = word_q.nib_view[pix_idx[3:0]];  // idx stays below 16 here
	end

	always_comb
	begin
		pix.valid  = valid_q;
		pix.colour = mode_q ? nib_colour : attr_colour;
	end

endmodule

/* logic/video_timing.sv */
`timescale 1ns/1ns

module video_timing (
	input  logic                              clk,
	input  logic                              rst_n,
	output video_timing_pkg::timing_strobes_t strobes
);

	logic [1:0]              phase;  // position inside 4-clock dram slot
	video_timing_pkg::hcnt_t hcnt;   // pixel within line
	video_timing_pkg::vcnt_t vcnt;   // line within frame

	logic line_end;   // last clock of line
	logic frame_end;  // last line of frame
	logic in_vpix;    // vcnt within display lines

	assign line_end  = (hcnt == video_timing_pkg::hcnt_t'(video_timing_pkg::LINE_CLKS - 1));
	assign frame_end = (vcnt == video_timing_pkg::vcnt_t'(video_timing_pkg::FRAME_LINES - 1));

	assign in_vpix = (vcnt >= video_timing_pkg::vcnt_t'(video_timing_pkg::VPIX_FIRST)) &&
	                 (vcnt <= video_timing_pkg::vcnt_t'(video_timing_pkg::VPIX_LAST));

	// raster counters
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			phase <= '0;
			hcnt  <= '0;
			vcnt  <= '0;
		end
		else
		begin
			phase <= phase + 2'd1;  // free running, wraps every slot
			if (line_end)
			begin
				hcnt <= '0;
				if (frame_end)
					vcnt <= '0;
				else
					vcnt <= vcnt + 1'b1;
			end
			else
				hcnt <= hcnt + 1'b1;
		end
	end

	// strobes are registered, so decode one clock early
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			strobes <= '0;
		else
		begin
			strobes.c2   <= (phase == 2'd1);  // high at phase 2
			strobes.c3   <= (phase == 2'd2);  // high at phase 3
			strobes.vpix <= in_vpix;
			// window pulses land on the c3 of their slot
			strobes.fetch_start <= (hcnt ==
				video_timing_pkg::hcnt_t'(video_timing_pkg::FETCH_START_X + 2));
			strobes.fetch_end   <= (hcnt ==
				video_timing_pkg::hcnt_t'(video_timing_pkg::FETCH_END_X + 2));
		end
	end

endmodule

/* logic/video_timing_pkg.sv */
package video_timing_pkg;

	// raster geometry in pixel clocks and lines
	localparam int LINE_CLKS   = 512;  // clocks per line
	localparam int FRAME_LINES = 8;    // lines per frame

	localparam int VPIX_FIRST = 2;  // first display line
	localparam int VPIX_LAST  = 5;  // last display line

	localparam int FETCH_START_X = 64;   // slot that opens the request window
	localparam int FETCH_END_X   = 320;  // slot that closes it

	localparam int FETCH_CLKS      = 64;  // one fetch cycle = 16 dram slots
	localparam int WORDS_PER_FETCH = 4;   // 16-bit words per fetch cycle

	localparam int HCNT_W = $clog2(LINE_CLKS);
	localparam int VCNT_W = $clog2(FRAME_LINES);

	typedef logic [HCNT_W-1:0] hcnt_t;  // pixel counter
	typedef logic [VCNT_W-1:0] vcnt_t;  // line counter

	// strobes from the raster counters to the fetcher
	typedef struct packed {
		logic c2;           // slot phase 2
		logic c3;           // last clock of slot
		logic vpix;         // display lines
		logic fetch_start;  // on c3 at FETCH_START_X
		logic fetch_end;    // on c3 at FETCH_END_X
	} timing_strobes_t;

endpackage

/* logic/video_top.sv */
`timescale 1ns/1ns

module video_top (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       mode_16c,      // changed only outside the window
	input  logic [15:0]                video_data,    // from dram arbiter
	input  logic                       video_strobe,
	output logic                       video_go,      // to dram arbiter
	output logic                       fetch_sync,
	output video_data_pkg::pixel_out_t pix
);

	video_timing_pkg::timing_strobes_t strobes;
	video_data_pkg::pic_word_t         pic_word;
	logic                              load;
	logic                              load_valid;

	// raster counters and window decode
	video_timing u_video_timing (
		.clk     (clk),
		.rst_n   (rst_n),
		.strobes (strobes)
	);

	// dram words into picture words
	video_fetch u_video_fetch (
		.clk          (clk),
		.rst_n        (rst_n),
		.strobes      (strobes),
		.video_data   (video_data),
		.video_strobe (video_strobe),
		.video_go     (video_go),
		.fetch_sync   (fetch_sync),
		.pic_word     (pic_word),
		.load         (load),
		.load_valid   (load_valid)
	);

	// picture words into colour indices
	video_render u_video_render (
		.clk        (clk),
		.rst_n      (rst_n),
		.mode_16c   (mode_16c),
		.pic_word   (pic_word),
		.load       (load),
		.load_valid (load_valid),
		.pix        (pix)
	);

endmodule

/* run.sh */
#!/bin/sh
# build and run with Verilator, then look for the pass line in sim.log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_video_top -f src.f \
	&& ./obj_dir/Vtb_video_top > sim.log 2>&1
grep -q "ALL CHECKS PASSED" sim.log 2>/dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }

/* src.f */
logic/video_timing_pkg.sv
logic/video_data_pkg.sv
logic/video_top.sv
logic/video_timing.sv
logic/video_fetch.sv
logic/video_render.sv
testbench/tb_video_top.sv

/* testbench/tb_video_top.sv */
`timescale 1ns/1ns

module tb_video_top;

	localparam int RUN_CYCLES = 3 * video_timing_pkg::FRAME_LINES * video_timing_pkg::LINE_CLKS;
	localparam int TIMEOUT_CYCLES = 2 * RUN_CYCLES;
	localparam int ARB_SLOTS = 12;  // 48 clocks of dram slots after fetch_sync
	localparam int GO_RISE = video_timing_pkg::FETCH_START_X + 4;  // clock after the slot's c3
	localparam int GO_FALL = video_timing_pkg::FETCH_END_X + 4;
	localparam int SYNC_OFS = 8;  // counter value 1 ends two slots after go rises

	typedef struct packed {
		logic       mode_16c;  // decode the pixel came from
		logic [3:0] colour;
	} exp_pix_t;

	logic                       clk;
	logic                       rst_n;
	logic                       mode_16c;
	logic [15:0]                video_data;
	logic                       video_strobe;
	logic                       video_go;
	logic                       fetch_sync;
	video_data_pkg::pixel_out_t pix;

	exp_pix_t    exp_q [$];   // one entry per clock of expected output
	int unsigned n;           // clocks since reset release
	int unsigned clk_count;   // every clock, for the timeout
	int          line_valid;  // valid clocks on current line
	logic [1:0]  modes_seen;  // decodes used so far

	video_top u_video_top (
		.clk          (clk),
		.rst_n        (rst_n),
		.mode_16c     (mode_16c),
		.video_data   (video_data),
		.video_strobe (video_strobe),
		.video_go     (video_go),
		.fetch_sync   (fetch_sync),
		.pix          (pix)
	);

	always #20 clk = ~clk;

	task automatic end_with_failure();
		$display("CHECKS FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_mismatch(input string test, input int expected, input int actual);
		$display("[FAIL] %s: expected %0h, actual %0h", test, expected, actual);
		end_with_failure();
	endtask

	task automatic report_error(input string what);
		$display("%s", what);
		end_with_failure();
	endtask

	// expand one picture word into per-clock colours
	task automatic predict_pixels(input video_data_pkg::pic_word_t pw, input logic mode);
		video_data_pkg::attr_pair_t pair;
		exp_pix_t                   p;
		int                         reps;
		reps = mode ? video_data_pkg::PIX_CLKS_16C : video_data_pkg::PIX_CLKS_ATTR;
		p.mode_16c = mode;
		for (int k = 0; k < video_timing_pkg::FETCH_CLKS / reps; k++)
		begin
			pair = pw.attr_view[k / 8];
			if (mode)
				p.colour = pw.nib_view[k];
			else if (pair.bitmap[7 - k % 8])  // set bit = ink
				p.colour = {pair.attr[video_data_pkg::ATTR_BRIGHT_BIT],
				            pair.attr[video_data_pkg::ATTR_INK_LSB +: 3]};
			else
				p.colour = {pair.attr[video_data_pkg::ATTR_BRIGHT_BIT],
				            pair.attr[video_data_pkg::ATTR_PAPER_LSB +: 3]};
			repeat (reps) exp_q.push_back(p);
		end
	endtask

	// dram arbiter, four words in random slots after fetch_sync
	task automatic serve_fetch_cycle();
		logic [15:0]               words [video_timing_pkg::WORDS_PER_FETCH];
		video_data_pkg::pic_word_t pw;
		int                        need;
		int                        sent;
		int                        offset;
		logic                      hit;
		need = video_timing_pkg::WORDS_PER_FETCH;
		sent = 0;
		for (int slot = 0; slot < ARB_SLOTS; slot++)
		begin
			hit = ($urandom_range(ARB_SLOTS - 1 - slot, 0) < need);  // picks exactly 4
			offset = $urandom_range(3, 0);
			for (int c = 0; c < 4; c++)
			begin
				@(negedge clk);
				video_strobe = hit && (c == offset);
				video_data = 16'($urandom);  // junk between strobes
				if (video_strobe)
				begin
					words[sent] = video_data;
					sent++;
				end
			end
			if (hit)
				need--;
		end
		for (int i = 0; i < video_timing_pkg::WORDS_PER_FETCH; i++)
		begin
			pw.attr_view[i].bitmap = words[i][15:8];  // high byte to low lane
			pw.attr_view[i].attr   = words[i][7:0];
		end
		predict_pixels(pw, mode_16c);
	endtask

	always @(negedge clk)
	begin
		video_strobe = 1'b0;
		if (fetch_sync && video_go)
			serve_fetch_cycle();
	end

	always @(posedge clk)
	begin
		clk_count <= clk_count + 1;
		if (rst_n)
			n <= n + 1;
		if (clk_count >= TIMEOUT_CYCLES)
			report_error("timeout: simulation did not finish");
	end

	always @(negedge clk)
	begin : monitor
		int       hpos;
		int       line;
		logic     disp;
		logic     go_exp;
		logic     sync_exp;
		exp_pix_t want;
		hpos = n % video_timing_pkg::LINE_CLKS;
		line = (n / video_timing_pkg::LINE_CLKS) % video_timing_pkg::FRAME_LINES;
		disp = (line >= video_timing_pkg::VPIX_FIRST) && (line <= video_timing_pkg::VPIX_LAST);
		go_exp = disp && (hpos >= GO_RISE) && (hpos < GO_FALL);
		if (n == 0)  // reset, or the half clock after release
			assert (!video_go && !fetch_sync && !pix.valid)
			else report_mismatch("reset", 0, {video_go, fetch_sync, pix.valid});
		else
		begin
			if (n < video_timing_pkg::VPIX_FIRST * video_timing_pkg::LINE_CLKS + GO_RISE)
				assert (!video_go && !pix.valid)
				else report_mismatch("reset", 0, {video_go, pix.valid});
			assert (video_go == go_exp)
			else report_mismatch("request window", go_exp, video_go);
			if (n >= GO_RISE)  // fetch counter aligned by the first fetch_start
			begin
				sync_exp = ((n - GO_RISE) % video_timing_pkg::FETCH_CLKS == SYNC_OFS);
				assert (fetch_sync == sync_exp)
				else report_mismatch("fetch sync", sync_exp, fetch_sync);
			end
			if (pix.valid)
			begin
				line_valid++;
				assert (exp_q.size() > 0)
				else report_error("pixel valid with no expected pixel left in the queue");
				want = exp_q.pop_front();
				if (want.mode_16c)
				begin
					assert (pix.colour == want.colour)
					else report_mismatch("16-colour decode", want.colour, pix.colour);
				end
				else
				begin
					assert (pix.colour == want.colour)
					else report_mismatch("attribute decode", want.colour, pix.colour);
				end
			end
			if (hpos == video_timing_pkg::LINE_CLKS - 1)  // 4 fetch cycles per display line
			begin
				assert (line_valid == (disp ? GO_FALL - GO_RISE : 0))
				else report_mismatch("word count", disp ? GO_FALL - GO_RISE : 0, line_valid);
				line_valid = 0;
			end
		end
	end

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		mode_16c = 1'b0;
		video_data = '0;
		video_strobe = 1'b0;
		modes_seen = '0;
		void'($urandom(23));
		repeat (5) @(negedge clk);
		rst_n = 1'b1;
		for (int f = 0; f < 3; f++)
		begin
			// frame start, video_go low
			if (f == 2 && modes_seen != 2'b11)
				mode_16c = !modes_seen[1];  // last frame runs the decode not yet seen
			else
				mode_16c = 1'($urandom_range(1, 0));
			modes_seen[mode_16c] = 1'b1;
			repeat (RUN_CYCLES / 3) @(negedge clk);
		end
		assert (exp_q.size() == 0)
		begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
		else
			report_error("pixel queue not drained");
	end

endmodule
